// ==== cpu_operand_fetch.f ====
+incdir+source
source/cpu_pkg.sv
source/ram_dualport.sv
source/cpu_gpr.sv
source/cpu_decode.sv
source/cpu_operand.sv
source/cpu_operand_fetch.sv
dv/cpu_operand_fetch_assert.sv
dv/cpu_operand_fetch_tb.sv

// ==== dv/cpu_operand_fetch_assert.sv ====
// operand-fetch checker
// shadow register model fed from write-back, expected operands carried
// two cycles and compared with the stage outputs
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_operand_fetch_assert (
	input logic                       clk,
	input logic                       reset,
	input logic                       instr_valid,
	input logic [31:0]                instr,
	input logic                       wb_en,
	input logic [`CPU_ADDR_WIDTH-1:0] wb_addr,
	input logic [`CPU_DATA_WIDTH-1:0] wb_data,
	input logic                       op_valid,
	input cpu_pkg::opcode_t           op_code,
	input logic [`CPU_DATA_WIDTH-1:0] src0,
	input logic [`CPU_DATA_WIDTH-1:0] src1,
	input logic [`CPU_DATA_WIDTH-1:0] store_data
);

	localparam int PAD = `CPU_DATA_WIDTH - 16;

	int fail_count = 0;

	logic [`CPU_DATA_WIDTH-1:0] shadow [1 << `CPU_ADDR_WIDTH];
	logic                       exp_valid [2];
	cpu_pkg::opcode_t           exp_op    [2];
	logic [`CPU_DATA_WIDTH-1:0] exp_src0  [2];
	logic [`CPU_DATA_WIDTH-1:0] exp_src1  [2];
	logic [`CPU_DATA_WIDTH-1:0] exp_store [2];

	// value an instruction accepted at this edge must see
	function automatic logic [`CPU_DATA_WIDTH-1:0] reg_value(
		input logic [`CPU_ADDR_WIDTH-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		if (wb_en && (wb_addr == addr)) begin
			return wb_data;
		end
		return shadow[addr];
	endfunction

	always @(posedge clk) begin
		if (wb_en) begin
			shadow[wb_addr] <= wb_data;
		end
	end

	// ----------------------------------------------------------------------
	// expected operands two stages deep
	// ----------------------------------------------------------------------
	always @(posedge clk or posedge reset) begin : model
		logic [`CPU_DATA_WIDTH-1:0] rt_val;
		logic [15:0]                imm;
		if (reset) begin
			exp_valid[0] <= 1'b0;
			exp_valid[1] <= 1'b0;
		end else begin
			rt_val = reg_value(instr[20:16]);
			imm = instr[15:0];
			exp_valid[0] <= instr_valid;
			exp_src0[0]  <= reg_value(instr[25:21]);
			exp_store[0] <= rt_val;
			exp_op[0]    <= cpu_pkg::opcode_t'(instr[31:26]);
			case (instr[31:26])
				6'h04: begin
					exp_src1[0] <= rt_val;
				end
				6'h08, 6'h23, 6'h2b: begin
					exp_src1[0] <= {{PAD{imm[15]}}, imm};
				end
				6'h0c, 6'h0d: begin
					exp_src1[0] <= {{PAD{1'b0}}, imm};
				end
				6'h0f: begin
					exp_src1[0] <= {imm, {PAD{1'b0}}};
				end
				// special and anything unknown
				default: begin
					exp_op[0]   <= cpu_pkg::OP_SPECIAL;
					exp_src1[0] <= rt_val;
				end
			endcase
			exp_valid[1] <= exp_valid[0];
			exp_op[1]    <= exp_op[0];
			exp_src0[1]  <= exp_src0[0];
			exp_src1[1]  <= exp_src1[0];
			exp_store[1] <= exp_store[0];
		end
	end

	// ----------------------------------------------------------------------
	// assertions
	// ----------------------------------------------------------------------
	a_reset_clear: assert property (@(posedge clk)
		reset && $past(reset) |-> !op_valid && src0 == '0 && src1 == '0 && store_data == '0)
		else begin
			fail_count++;
			$error("outputs not cleared while reset is high");
		end

	a_latency: assert property (@(posedge clk) disable iff (reset)
		op_valid == exp_valid[1])
		else begin
			fail_count++;
			$error("op_valid expected %0b actual %0b", $sampled(exp_valid[1]),
				$sampled(op_valid));
		end

	a_op_code: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> op_code == exp_op[1])
		else begin
			fail_count++;
			$error("op_code expected %h actual %h", $sampled(exp_op[1]), $sampled(op_code));
		end

	a_src0: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> src0 == exp_src0[1])
		else begin
			fail_count++;
			$error("src0 expected %h actual %h", $sampled(exp_src0[1]), $sampled(src0));
		end

	a_src1: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> src1 == exp_src1[1])
		else begin
			fail_count++;
			$error("src1 expected %h actual %h", $sampled(exp_src1[1]), $sampled(src1));
		end

	a_store_data: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> store_data == exp_store[1])
		else begin
			fail_count++;
			$error("store_data expected %h actual %h", $sampled(exp_store[1]),
				$sampled(store_data));
		end

endmodule

bind cpu_operand_fetch cpu_operand_fetch_assert i_cpu_operand_fetch_assert (
	.clk         (clk),
	.reset       (reset),
	.instr_valid (instr_valid),
	.instr       (instr),
	.wb_en       (wb_en),
	.wb_addr     (wb_addr),
	.wb_data     (wb_data),
	.op_valid    (op_valid),
	.op_code     (op_code),
	.src0        (src0),
	.src1        (src1),
	.store_data  (store_data)
);

// ==== dv/cpu_operand_fetch_tb.sv ====
// operand-fetch testbench
// directed and random instruction streams with write-back traffic,
// checked by the bound assertion module
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_operand_fetch_tb;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_CYCLES = 400;
	// directed tests together stay well below this
	localparam int DIRECTED_CYCLES = 150;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;

	logic                       clk;
	logic                       reset;
	logic                       instr_valid;
	logic [31:0]                instr;
	logic                       wb_en;
	logic [`CPU_ADDR_WIDTH-1:0] wb_addr;
	logic [`CPU_DATA_WIDTH-1:0] wb_data;
	logic                       op_valid;
	cpu_pkg::opcode_t           op_code;
	logic [`CPU_DATA_WIDTH-1:0] src0;
	logic [`CPU_DATA_WIDTH-1:0] src1;
	logic [`CPU_DATA_WIDTH-1:0] store_data;

	int tests_run = 0;
	int tests_failed = 0;
	int fails_before = 0;

	cpu_operand_fetch i_cpu_operand_fetch (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_en       (wb_en),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.op_valid    (op_valid),
		.op_code     (op_code),
		.src0        (src0),
		.src1        (src1),
		.store_data  (store_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * TIMEOUT_CYCLES);
		$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] make_instr(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic drive(input logic iv, input logic [31:0] iw, input logic we,
		input logic [4:0] wa, input logic [31:0] wd);
		@(negedge clk);
		instr_valid = iv;
		instr = iw;
		wb_en = we;
		wb_addr = wa;
		wb_data = wd;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) drive(1'b0, '0, 1'b0, '0, '0);
	endtask

	task automatic finish_test(input string name);
		int fails;
		// wait out the two-cycle latency plus one edge for the last check
		idle(3);
		fails = i_cpu_operand_fetch.i_cpu_operand_fetch_assert.fail_count - fails_before;
		fails_before = i_cpu_operand_fetch.i_cpu_operand_fetch_assert.fail_count;
		tests_run++;
		if (fails != 0) begin
			tests_failed++;
			$display("ERROR test %s: expected 0 assertion failures, actual %0d", name, fails);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	initial begin : stimulus
		logic [5:0]  imm_ops  [6];
		logic [15:0] imm_vals [3];
		logic [5:0]  rand_ops [9];
		logic [4:0]  rs;
		logic [4:0]  rt;
		int          total_fails;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		wb_en = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		void'($urandom(32'h65cf_0f6f));
		imm_ops = '{cpu_pkg::OP_ADDI, cpu_pkg::OP_LW, cpu_pkg::OP_SW,
			cpu_pkg::OP_ANDI, cpu_pkg::OP_ORI, cpu_pkg::OP_LUI};
		rand_ops = '{cpu_pkg::OP_SPECIAL, cpu_pkg::OP_BEQ, cpu_pkg::OP_ADDI, cpu_pkg::OP_ANDI,
			cpu_pkg::OP_ORI, cpu_pkg::OP_LUI, cpu_pkg::OP_LW, cpu_pkg::OP_SW, 6'h3f};

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// no instruction yet so op_valid stays low
		idle(6);
		finish_test("reset");

		// every register gets a known value first
		for (int r = 0; r < 32; r++) begin
			drive(1'b0, '0, 1'b1, r[4:0], $urandom());
		end
		for (int i = 0; i < 24; i++) begin
			rs = 5'(1 + $urandom % 31);
			rt = 5'(1 + $urandom % 31);
			drive(1'b1, make_instr((i % 2) ? cpu_pkg::OP_BEQ : cpu_pkg::OP_SPECIAL, rs, rt,
				16'($urandom())), 1'b0, '0, '0);
			if (i % 8 == 7) begin
				idle(1);
			end
		end
		finish_test("register_register");

		drive(1'b0, '0, 1'b1, 5'd0, 32'hdead_beef);
		drive(1'b1, make_instr(cpu_pkg::OP_SPECIAL, 5'd0, 5'd5, 16'h0), 1'b0, '0, '0);
		drive(1'b1, make_instr(cpu_pkg::OP_BEQ, 5'd7, 5'd0, 16'h0010), 1'b0, '0, '0);
		drive(1'b1, make_instr(cpu_pkg::OP_SW, 5'd0, 5'd0, 16'hfff0), 1'b1, 5'd0,
			32'h1234_5678);
		finish_test("register_zero");

		imm_vals = '{16'h8001, 16'h7fff, 16'($urandom())};
		foreach (imm_ops[k]) begin
			foreach (imm_vals[m]) begin
				rs = 5'(1 + $urandom % 31);
				rt = 5'(1 + $urandom % 31);
				drive(1'b1, make_instr(imm_ops[k], rs, rt, imm_vals[m]), 1'b0, '0, '0);
			end
		end
		finish_test("immediate");

		// write-back on the same edge as the read and later reads of it
		drive(1'b1, make_instr(cpu_pkg::OP_SPECIAL, 5'd9, 5'd3, 16'h0), 1'b1, 5'd9,
			32'h0a0b_0c0d);
		drive(1'b1, make_instr(cpu_pkg::OP_ORI, 5'd4, 5'd9, 16'h00ff), 1'b1, 5'd9,
			32'h1111_2222);
		drive(1'b1, make_instr(cpu_pkg::OP_SPECIAL, 5'd12, 5'd12, 16'h0), 1'b1, 5'd12,
			32'hcafe_f00d);
		idle(2);
		drive(1'b1, make_instr(cpu_pkg::OP_SPECIAL, 5'd9, 5'd12, 16'h0), 1'b0, '0, '0);
		drive(1'b1, make_instr(cpu_pkg::OP_LW, 5'd12, 5'd9, 16'h0004), 1'b0, '0, '0);
		finish_test("write_through");

		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			rs = 5'($urandom % 32);
			rt = 5'($urandom % 32);
			drive(($urandom % 10) < 7, make_instr(rand_ops[$urandom % 9], rs, rt,
				16'($urandom())), 1'($urandom % 2), ($urandom % 4 == 0) ? rs : 5'($urandom),
				$urandom());
		end
		finish_test("random");

		total_fails = i_cpu_operand_fetch.i_cpu_operand_fetch_assert.fail_count;
		$display("summary: %0d tests run, %0d failed, %0d assertion failures", tests_run,
			tests_failed, total_fails);
		if (tests_failed == 0 && total_fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== source/cpu_decode.sv ====
// instruction decoder
// splits the instruction into its fields, starts both register reads
// and holds the immediate information for one cycle so it meets the read data
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_decode (
	input  logic                        clk,
	input  logic                        reset,

	input  logic                        instr_valid,
	input  logic [31:0]                 instr,

	output logic                        read0_en,
	output logic [`CPU_ADDR_WIDTH-1:0]  read0_addr,
	output logic                        read1_en,
	output logic [`CPU_ADDR_WIDTH-1:0]  read1_addr,

	output logic                        dec_valid,
	output cpu_pkg::opcode_t            dec_op,
	output cpu_pkg::imm_mode_t          dec_imm_mode,
	output logic [cpu_pkg::IMM_WIDTH-1:0] dec_imm,
	output logic                        dec_rs_zero,
	output logic                        dec_rt_zero
);

	cpu_pkg::opcode_t op;
	logic [`CPU_ADDR_WIDTH-1:0] rs;
	logic [`CPU_ADDR_WIDTH-1:0] rt;

	// field slicing
	assign op = cpu_pkg::to_opcode(instr[31:26]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];

	// rt is read even for immediate forms, store data and beq need it
	assign read0_en   = instr_valid;
	assign read0_addr = rs;
	assign read1_en   = instr_valid;
	assign read1_addr = rt;

	// ----------------------------------------------------------------------
	// decode stage register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec_op       <= op;
			dec_imm_mode <= cpu_pkg::imm_mode_of(op);
			dec_imm      <= instr[15:0];
			dec_rs_zero  <= (rs == '0);
			dec_rt_zero  <= (rt == '0);
		end
	end

endmodule

// ==== source/cpu_gpr.sv ====
// general purpose register file
// one write port, two synchronous read ports with write-through
// built from two dual-port rams (type 1) or a register array (type 2)
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_gpr #(
	parameter int GPR_TYPE   = `CPU_GPR_TYPE,
	parameter int DATA_WIDTH = `CPU_DATA_WIDTH,
	parameter int ADDR_WIDTH = `CPU_ADDR_WIDTH
) (
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  write_en,
	input  logic [ADDR_WIDTH-1:0] write_addr,
	input  logic [DATA_WIDTH-1:0] write_data,

	input  logic                  read0_en,
	input  logic [ADDR_WIDTH-1:0] read0_addr,
	output logic [DATA_WIDTH-1:0] read0_data,

	input  logic                  read1_en,
	input  logic [ADDR_WIDTH-1:0] read1_addr,
	output logic [DATA_WIDTH-1:0] read1_data
);

	// read ports gathered so both builds share one loop
	logic                  rd_en   [2];
	logic [ADDR_WIDTH-1:0] rd_addr [2];
	logic [DATA_WIDTH-1:0] rd_data [2];

	assign rd_en[0]   = read0_en;
	assign rd_en[1]   = read1_en;
	assign rd_addr[0] = read0_addr;
	assign rd_addr[1] = read1_addr;
	assign read0_data = rd_data[0];
	assign read1_data = rd_data[1];

	if (GPR_TYPE == 1) begin : g_dpram
		// ----------------------------------------------------------------------
		// one ram copy per read port, all copies written together
		// ----------------------------------------------------------------------
		for (genvar i = 0; i < 2; i++) begin : g_port
			logic [DATA_WIDTH-1:0] ram_dout;
			logic                  wt_hit;
			logic [DATA_WIDTH-1:0] wt_data;

			ram_dualport #(
				.DATA_WIDTH (DATA_WIDTH),
				.ADDR_WIDTH (ADDR_WIDTH)
			) i_ram_dualport (
				.clk   (clk),
				.en0   (write_en),
				.we0   (1'b1),
				.addr0 (write_addr),
				.din0  (write_data),
				.dout0 (),
				.en1   (rd_en[i]),
				.we1   (1'b0),
				.addr1 (rd_addr[i]),
				.din1  ({DATA_WIDTH{1'b0}}),
				.dout1 (ram_dout)
			);

			// ram returns old data on a same-edge write, so remember the hit
			always_ff @(posedge clk or posedge reset) begin
				if (reset) begin
					wt_hit <= 1'b0;
				end else if (rd_en[i]) begin
					wt_hit <= write_en && (write_addr == rd_addr[i]);
				end
			end

			always_ff @(posedge clk) begin
				if (rd_en[i]) begin
					wt_data <= write_data;
				end
			end

			assign rd_data[i] = wt_hit ? wt_data : ram_dout;
		end
	end else begin : g_array
		// ----------------------------------------------------------------------
		// plain register array
		// ----------------------------------------------------------------------
		logic [DATA_WIDTH-1:0] regs [1 << ADDR_WIDTH];

		always_ff @(posedge clk) begin
			if (write_en) begin
				regs[write_addr] <= write_data;
			end
		end

		for (genvar i = 0; i < 2; i++) begin : g_port
			always_ff @(posedge clk) begin
				if (rd_en[i]) begin
					rd_data[i] <= (write_en && (write_addr == rd_addr[i])) ?
						write_data : regs[rd_addr[i]];
				end
			end
		end
	end

endmodule

// ==== source/cpu_macros.svh ====
// cpu macros
// widths and register file implementation for the operand-fetch stage
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ----------------------------------------------------------------------
// datapath
// ----------------------------------------------------------------------

// register and operand width
`define CPU_DATA_WIDTH 32

// register address width, 32 registers
`define CPU_ADDR_WIDTH 5

// register file build: 1 dual dp-ram, 2 register array
`define CPU_GPR_TYPE 1

`endif

// ==== source/cpu_operand.sv ====
// operand former
// builds the two source operands and the store data from register reads,
// forcing register 0 to zero and inserting the extended immediate
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_operand (
	input  logic                          clk,
	input  logic                          reset,

	input  logic                          dec_valid,
	input  cpu_pkg::opcode_t              dec_op,
	input  cpu_pkg::imm_mode_t            dec_imm_mode,
	input  logic [cpu_pkg::IMM_WIDTH-1:0] dec_imm,
	input  logic                          dec_rs_zero,
	input  logic                          dec_rt_zero,

	input  logic [`CPU_DATA_WIDTH-1:0]    read0_data,
	input  logic [`CPU_DATA_WIDTH-1:0]    read1_data,

	output logic                          op_valid,
	output cpu_pkg::opcode_t              op_code,
	output logic [`CPU_DATA_WIDTH-1:0]    src0,
	output logic [`CPU_DATA_WIDTH-1:0]    src1,
	output logic [`CPU_DATA_WIDTH-1:0]    store_data
);

	localparam int PAD = `CPU_DATA_WIDTH - cpu_pkg::IMM_WIDTH;

	logic [`CPU_DATA_WIDTH-1:0] rs_val;
	logic [`CPU_DATA_WIDTH-1:0] rt_val;
	logic [`CPU_DATA_WIDTH-1:0] src1_next;

	// register 0 reads as zero whatever was written to it
	assign rs_val = dec_rs_zero ? '0 : read0_data;
	assign rt_val = dec_rt_zero ? '0 : read1_data;

	always_comb begin
		case (dec_imm_mode)
			cpu_pkg::IMM_SIGN:  src1_next = {{PAD{dec_imm[cpu_pkg::IMM_WIDTH-1]}}, dec_imm};
			cpu_pkg::IMM_ZERO:  src1_next = {{PAD{1'b0}}, dec_imm};
			cpu_pkg::IMM_UPPER: src1_next = {dec_imm, {PAD{1'b0}}};
			default:            src1_next = rt_val;
		endcase
	end

	// ----------------------------------------------------------------------
	// output register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			op_valid   <= 1'b0;
			op_code    <= cpu_pkg::OP_SPECIAL;
			src0       <= '0;
			src1       <= '0;
			store_data <= '0;
		end else begin
			op_valid <= dec_valid;
			// outputs hold between instructions
			if (dec_valid) begin
				op_code    <= dec_op;
				src0       <= rs_val;
				src1       <= src1_next;
				store_data <= rt_val;
			end
		end
	end

endmodule

// ==== source/cpu_operand_fetch.sv ====
// operand-fetch stage
// decoder, register file and operand former, two cycles from
// instruction to operands, write-back taken as a plain strobe
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_operand_fetch (
	input  logic                        clk,
	input  logic                        reset,

	input  logic                        instr_valid,
	input  logic [31:0]                 instr,

	input  logic                        wb_en,
	input  logic [`CPU_ADDR_WIDTH-1:0]  wb_addr,
	input  logic [`CPU_DATA_WIDTH-1:0]  wb_data,

	output logic                        op_valid,
	output cpu_pkg::opcode_t            op_code,
	output logic [`CPU_DATA_WIDTH-1:0]  src0,
	output logic [`CPU_DATA_WIDTH-1:0]  src1,
	output logic [`CPU_DATA_WIDTH-1:0]  store_data
);

	logic                          read0_en;
	logic [`CPU_ADDR_WIDTH-1:0]    read0_addr;
	logic [`CPU_DATA_WIDTH-1:0]    read0_data;
	logic                          read1_en;
	logic [`CPU_ADDR_WIDTH-1:0]    read1_addr;
	logic [`CPU_DATA_WIDTH-1:0]    read1_data;

	logic                          dec_valid;
	cpu_pkg::opcode_t              dec_op;
	cpu_pkg::imm_mode_t            dec_imm_mode;
	logic [cpu_pkg::IMM_WIDTH-1:0] dec_imm;
	logic                          dec_rs_zero;
	logic                          dec_rt_zero;

	cpu_decode i_cpu_decode (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.read0_en     (read0_en),
		.read0_addr   (read0_addr),
		.read1_en     (read1_en),
		.read1_addr   (read1_addr),
		.dec_valid    (dec_valid),
		.dec_op       (dec_op),
		.dec_imm_mode (dec_imm_mode),
		.dec_imm      (dec_imm),
		.dec_rs_zero  (dec_rs_zero),
		.dec_rt_zero  (dec_rt_zero)
	);

	// write-back goes straight to the write port
	cpu_gpr #(
		.GPR_TYPE   (`CPU_GPR_TYPE),
		.DATA_WIDTH (`CPU_DATA_WIDTH),
		.ADDR_WIDTH (`CPU_ADDR_WIDTH)
	) i_cpu_gpr (
		.clk        (clk),
		.reset      (reset),
		.write_en   (wb_en),
		.write_addr (wb_addr),
		.write_data (wb_data),
		.read0_en   (read0_en),
		.read0_addr (read0_addr),
		.read0_data (read0_data),
		.read1_en   (read1_en),
		.read1_addr (read1_addr),
		.read1_data (read1_data)
	);

	cpu_operand i_cpu_operand (
		.clk          (clk),
		.reset        (reset),
		.dec_valid    (dec_valid),
		.dec_op       (dec_op),
		.dec_imm_mode (dec_imm_mode),
		.dec_imm      (dec_imm),
		.dec_rs_zero  (dec_rs_zero),
		.dec_rt_zero  (dec_rt_zero),
		.read0_data   (read0_data),
		.read1_data   (read1_data),
		.op_valid     (op_valid),
		.op_code      (op_code),
		.src0         (src0),
		.src1         (src1),
		.store_data   (store_data)
	);

endmodule

// ==== source/cpu_pkg.sv ====
// cpu package
// opcode and immediate-mode types for the operand-fetch stage
package cpu_pkg;

	localparam int IMM_WIDTH = 16;

	// primary opcodes handled here
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_ADDI    = 6'h08,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	// how the second operand is formed
	typedef enum logic [1:0] {
		IMM_NONE  = 2'd0,
		IMM_SIGN  = 2'd1,
		IMM_ZERO  = 2'd2,
		IMM_UPPER = 2'd3
	} imm_mode_t;

	// raw field to opcode, unknown codes run as special
	function automatic opcode_t to_opcode(input logic [5:0] field);
		opcode_t op;
		case (field)
			OP_BEQ, OP_ADDI, OP_ANDI, OP_ORI, OP_LUI, OP_LW, OP_SW: op = opcode_t'(field);
			default: op = OP_SPECIAL;
		endcase
		return op;
	endfunction

	function automatic imm_mode_t imm_mode_of(input opcode_t op);
		imm_mode_t mode;
		case (op)
			OP_ADDI, OP_LW, OP_SW: mode = IMM_SIGN;
			OP_ANDI, OP_ORI:       mode = IMM_ZERO;
			OP_LUI:                mode = IMM_UPPER;
			default:               mode = IMM_NONE;
		endcase
		return mode;
	endfunction

endpackage

// ==== source/ram_dualport.sv ====
// dual-port ram
// two synchronous read-before-write ports sharing one array
`timescale 1ns/1ps
`include "cpu_macros.svh"

module ram_dualport #(
	parameter int DATA_WIDTH = `CPU_DATA_WIDTH,
	parameter int ADDR_WIDTH = `CPU_ADDR_WIDTH
) (
	input  logic                  clk,

	input  logic                  en0,
	input  logic                  we0,
	input  logic [ADDR_WIDTH-1:0] addr0,
	input  logic [DATA_WIDTH-1:0] din0,
	output logic [DATA_WIDTH-1:0] dout0,

	input  logic                  en1,
	input  logic                  we1,
	input  logic [ADDR_WIDTH-1:0] addr1,
	input  logic [DATA_WIDTH-1:0] din1,
	output logic [DATA_WIDTH-1:0] dout1
);

	logic [DATA_WIDTH-1:0] mem [1 << ADDR_WIDTH];

	// port 1 wins on a same-address collision
	always_ff @(posedge clk) begin
		if (en0) begin
			dout0 <= mem[addr0];
			if (we0) begin
				mem[addr0] <= din0;
			end
		end
		if (en1) begin
			dout1 <= mem[addr1];
			if (we1) begin
				mem[addr1] <= din1;
			end
		end
	end

endmodule
